// ==== hw/coco_pkg.sv ====
// colour computer memory map definitions
package coco_pkg;

  // bus widths
  localparam int unsigned addr_w = 16;
  localparam int unsigned data_w = 8;

  // cpu address map
  localparam logic [addr_w-1:0] ram_base  = 16'h0000;
  localparam logic [addr_w-1:0] ram_top   = 16'h7fff;
  localparam logic [addr_w-1:0] rom8_base = 16'h8000; // extended basic
  localparam logic [addr_w-1:0] roma_base = 16'ha000; // colour basic
  localparam logic [addr_w-1:0] romc_base = 16'hc000; // cart, stops at 0xfeff
  localparam logic [addr_w-1:0] pia1_base = 16'hff20; // second pia block

  // memory sizes
  localparam int unsigned ram_addr_w  = 15;
  localparam int unsigned rom_addr_w  = 15; // four 8k banks
  localparam int unsigned cart_addr_w = 14;

  localparam logic [ram_addr_w-1:0] cold_start_addr = 15'h0071; // basic warm-start flag
  localparam logic [addr_w-1:0]     cart_min_len    = 16'h0100;

  // download port indexes
  localparam logic loader_idx_rom  = 1'b0;
  localparam logic loader_idx_cart = 1'b1;

  localparam logic [data_w-1:0] unmapped_data = 8'hff; // floating bus

  // port b register offsets inside the block
  localparam logic [4:0] reg_pb_data = 5'd2;
  localparam logic [4:0] reg_pb_ddr  = 5'd3;

  localparam int unsigned pb_bank_bit = 2; // dragon 64 rom bank
  localparam int unsigned pb_snd_bit  = 1; // single bit sound

  // rom window view, 8k pages
  typedef struct packed {
    logic [2:0]  page;
    logic [12:0] offset;
  } rom_view_t;

  // io page view, 32 byte device slots
  typedef struct packed {
    logic [7:0] hi_page;
    logic [2:0] slot;
    logic [4:0] reg_sel;
  } io_view_t;

  typedef union packed {
    rom_view_t rom;
    io_view_t  io;
  } cpu_addr_u;

  // one cycle cpu request
  typedef struct packed {
    logic              rd;
    logic              wr;
    cpu_addr_u         addr;
    logic [data_w-1:0] wdata;
  } bus_req_t;

  // region selects, first six one-hot
  typedef struct packed {
    logic ram;
    logic rom8;
    logic roma;
    logic romc;
    logic pia1;
    logic none;
    logic rom_alt; // alternate dragon 64 bank
  } region_sel_t;

  // host download port
  typedef struct packed {
    logic              download;
    logic              wr;
    logic              index;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } loader_t;

endpackage

// ==== hw/apb_bus_slave.sv ====
// apb slave front end
`timescale 1ns/10ps
module apb_bus_slave (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [coco_pkg::addr_w-1:0] paddr,
  input  logic [coco_pkg::data_w-1:0] pwdata,
  input  coco_pkg::region_sel_t       sel,
  input  logic [coco_pkg::data_w-1:0] ram_rdata,
  input  logic [coco_pkg::data_w-1:0] rom_rdata,
  input  logic [coco_pkg::data_w-1:0] cart_rdata,
  input  logic [coco_pkg::data_w-1:0] pia_rdata,
  output coco_pkg::bus_req_t          req,
  output logic [coco_pkg::data_w-1:0] prdata,
  output logic                        pready
);

  logic                  setup_ph;  // psel without penable
  logic                  access_ph; // psel with penable
  coco_pkg::region_sel_t sel_q;     // region of the read in flight

  assign setup_ph  = psel & ~penable;
  assign access_ph = psel & penable;

  // reads launch in setup so the sync memories answer in access
  assign req.rd    = setup_ph & ~pwrite;
  // writes commit at the end of access
  assign req.wr    = access_ph & pwrite;
  assign req.addr  = paddr;
  assign req.wdata = pwdata;

  assign pready = access_ph; // no wait states

  // capture the decode alongside the memory read
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      sel_q      <= '0;
      sel_q.none <= 1'b1; // idle reads float
    end
    else if (req.rd)
    begin
      sel_q <= sel;
    end
  end

  // read data mux, like the cpu din select
  always_comb
  begin
    unique case (1'b1)
      sel_q.ram:              prdata = ram_rdata;
      sel_q.rom8, sel_q.roma: prdata = rom_rdata; // bank already chosen in the store
      sel_q.romc:             prdata = cart_rdata;
      sel_q.pia1:             prdata = pia_rdata;
      default:                prdata = coco_pkg::unmapped_data;
    endcase
  end

  // access phase always follows a setup phase
  penable_after_psel: assert property (
    @(posedge clk) disable iff (!reset_n)
    penable |-> $past(psel)
  ) else $error("penable without a preceding psel");

endmodule

// ==== hw/mem_map_decode.sv ====
// address map decoder
`timescale 1ns/10ps
module mem_map_decode (
  input  coco_pkg::cpu_addr_u   addr,
  input  logic                  dragon64,
  input  logic                  bank_ctl,
  output coco_pkg::region_sel_t sel
);

  logic [2:0] s; // device select, as the sam s lines

  // sam style device select
  always_comb
  begin
    if (addr.io.hi_page == coco_pkg::pia1_base[15:8])
    begin
      // io page, 32 byte slots; slot 3 and up all land on s7
      if (addr.io.slot > 3'd3)
        s = 3'd7;
      else
        s = {1'b1, addr.io.slot[1:0]};
    end
    else if (addr <= coco_pkg::ram_top)
      s = 3'd0;
    else if (addr.rom.page == coco_pkg::rom8_base[15:13])
      s = 3'd1;
    else if (addr.rom.page == coco_pkg::roma_base[15:13])
      s = 3'd2;
    else
      s = 3'd3; // 0xc000 up to 0xfeff
  end

  // 3-to-8 style fan out
  always_comb
  begin
    sel = '0;
    case (s)
      3'd0:    sel.ram  = 1'b1;
      3'd1:    sel.rom8 = 1'b1;
      3'd2:    sel.roma = 1'b1;
      3'd3:    sel.romc = 1'b1;
      3'd5:    sel.pia1 = 1'b1; // 0xff20 block
      default: ;
    endcase
    // first pia, spare io slots and vectors float
    sel.none = (addr.io.hi_page == coco_pkg::pia1_base[15:8]) &&
               (addr.io.slot != coco_pkg::pia1_base[7:5]);
    // alternate bank only on the 64
    sel.rom_alt = dragon64 & bank_ctl;
  end

  always_comb
  begin
    region_onehot: assert final (
      $onehot({sel.ram, sel.rom8, sel.roma, sel.romc, sel.pia1, sel.none})
    ) else $error("region select not one-hot");
  end

endmodule

// ==== hw/system_ram.sv ====
// 32k system ram
`timescale 1ns/10ps
module system_ram (
  input  logic                        clk,
  input  coco_pkg::bus_req_t          req,
  input  logic                        en,
  input  logic                        hard_reset,
  output logic [coco_pkg::data_w-1:0] rdata
);

  logic [coco_pkg::data_w-1:0] mem [2**coco_pkg::ram_addr_w];

  logic [coco_pkg::ram_addr_w-1:0] cpu_a;

  assign cpu_a = req.addr[coco_pkg::ram_addr_w-1:0]; // 0x0000-0x7fff

  always_ff @(posedge clk)
  begin
    // cpu port
    if (en && req.wr)
      mem[cpu_a] <= req.wdata;
    // second port forces a cold start, last write wins
    if (hard_reset)
      mem[coco_pkg::cold_start_addr] <= '0;
    if (en && req.rd)
      rdata <= mem[cpu_a]; // ready in the access cycle
  end

endmodule

// ==== hw/rom_bank_store.sv ====
// basic rom bank store
`timescale 1ns/10ps
module rom_bank_store (
  input  logic                        clk,
  input  coco_pkg::bus_req_t          req,
  input  logic                        en,
  input  logic                        alt,
  input  logic                        roma,
  input  coco_pkg::loader_t           ld,
  output logic [coco_pkg::data_w-1:0] rdata
);

  // banks: ext, bas, alt ext, alt bas
  logic [coco_pkg::data_w-1:0] mem [2**coco_pkg::rom_addr_w];

  logic [coco_pkg::rom_addr_w-1:0] cpu_a;
  logic [coco_pkg::rom_addr_w-1:0] ld_a;
  logic                            ld_we;

  // bank number is {alt, roma}, then the 8k offset
  assign cpu_a = {alt, roma, req.addr.rom.offset};
  assign ld_a  = ld.addr[coco_pkg::rom_addr_w-1:0]; // image laid out in bank order
  assign ld_we = ld.wr & (ld.index == coco_pkg::loader_idx_rom);

  always_ff @(posedge clk)
  begin
    if (ld_we)
      mem[ld_a] <= ld.data;
    // read only from the cpu side
    if (en && req.rd)
      rdata <= mem[cpu_a];
  end

endmodule

// ==== hw/cart_slot.sv ====
// cartridge slot
`timescale 1ns/10ps
module cart_slot (
  input  logic                        clk,
  input  logic                        reset_n,
  input  coco_pkg::bus_req_t          req,
  input  logic                        en,
  input  coco_pkg::loader_t           ld,
  output logic [coco_pkg::data_w-1:0] rdata,
  output logic                        cart_present
);

  logic [coco_pkg::data_w-1:0] mem [2**coco_pkg::cart_addr_w];

  logic [coco_pkg::data_w-1:0]      rdata_q;
  logic                             dl_q;     // last download level
  logic                             dl_fall;
  logic                             ld_we;
  logic [coco_pkg::cart_addr_w-1:0] cpu_a;

  assign cpu_a   = req.addr[coco_pkg::cart_addr_w-1:0]; // window base is 16k aligned
  assign ld_we   = ld.wr & (ld.index == coco_pkg::loader_idx_cart);
  assign dl_fall = dl_q & ~ld.download;

  always_ff @(posedge clk)
  begin
    if (ld_we)
      mem[ld.addr[coco_pkg::cart_addr_w-1:0]] <= ld.data;
    if (en && req.rd)
      rdata_q <= mem[cpu_a];
  end

  // presence is judged on the final loader address
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      dl_q         <= 1'b0;
      cart_present <= 1'b0;
    end
    else
    begin
      dl_q <= ld.download;
      if (dl_fall)
        cart_present <= ld.addr > coco_pkg::cart_min_len; // tiny loads are not carts
    end
  end

  // empty slot floats
  assign rdata = cart_present ? rdata_q : coco_pkg::unmapped_data;

  // cart bytes only arrive inside a download frame
  ld_wr_in_download: assert property (
    @(posedge clk) disable iff (!reset_n)
    ld_we |-> ld.download
  ) else $error("cartridge loader write outside a download");

endmodule

// ==== hw/pia1_port_b.sv ====
// second pia port b
`timescale 1ns/10ps
module pia1_port_b (
  input  logic                        clk,
  input  logic                        reset_n,
  input  coco_pkg::bus_req_t          req,
  input  logic                        en,
  output logic [coco_pkg::data_w-1:0] rdata,
  output logic                        bank_ctl,
  output logic                        sndout
);

  logic [coco_pkg::data_w-1:0] pb_data; // output register
  logic [coco_pkg::data_w-1:0] pb_ddr;  // 1 = output
  logic [4:0]                  reg_a;

  assign reg_a = req.addr.io.reg_sel;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      pb_data <= '0;
      pb_ddr  <= '0; // all inputs
    end
    else if (en && req.wr)
    begin
      if (reg_a == coco_pkg::reg_pb_data)
        pb_data <= req.wdata;
      else if (reg_a == coco_pkg::reg_pb_ddr)
        pb_ddr <= req.wdata;
    end
  end

  // registered read, lines up with the memories
  always_ff @(posedge clk)
  begin
    if (en && req.rd)
    begin
      case (reg_a)
        coco_pkg::reg_pb_data: rdata <= pb_data;
        coco_pkg::reg_pb_ddr:  rdata <= pb_ddr;
        default:               rdata <= coco_pkg::unmapped_data; // port a side dropped
      endcase
    end
  end

  // pin pulled high unless driven low as an output
  assign bank_ctl = pb_ddr[coco_pkg::pb_bank_bit] & ~pb_data[coco_pkg::pb_bank_bit];
  assign sndout   = pb_ddr[coco_pkg::pb_snd_bit] & pb_data[coco_pkg::pb_snd_bit];

endmodule

// ==== hw/coco_bus_top.sv ====
// colour computer bus top
`timescale 1ns/10ps
module coco_bus_top (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [coco_pkg::addr_w-1:0]   paddr,
  input  logic [coco_pkg::data_w-1:0]   pwdata,
  output logic [coco_pkg::data_w-1:0]   prdata,
  output logic                          pready,
  input  logic                          dragon64,
  input  logic                          hard_reset,
  input  logic                          ioctl_download,
  input  logic                          ioctl_wr,
  input  logic                          ioctl_index,
  input  logic [coco_pkg::addr_w-1:0]   ioctl_addr,
  input  logic [coco_pkg::data_w-1:0]   ioctl_data,
  output logic                          cart_present,
  output logic                          sndout
);

  coco_pkg::bus_req_t    req;
  coco_pkg::region_sel_t sel;
  coco_pkg::loader_t     ld;

  logic [coco_pkg::data_w-1:0] ram_rdata;
  logic [coco_pkg::data_w-1:0] rom_rdata;
  logic [coco_pkg::data_w-1:0] cart_rdata;
  logic [coco_pkg::data_w-1:0] pia_rdata;
  logic                        bank_ctl; // from port b back into the decode

  // host loader bundle
  assign ld = {ioctl_download, ioctl_wr, ioctl_index, ioctl_addr, ioctl_data};

  apb_bus_slave apb_bus_slave_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .sel        (sel),
    .ram_rdata  (ram_rdata),
    .rom_rdata  (rom_rdata),
    .cart_rdata (cart_rdata),
    .pia_rdata  (pia_rdata),
    .req        (req),
    .prdata     (prdata),
    .pready     (pready)
  );

  mem_map_decode mem_map_decode_i (
    .addr     (req.addr),
    .dragon64 (dragon64),
    .bank_ctl (bank_ctl),
    .sel      (sel)
  );

  system_ram system_ram_i (
    .clk        (clk),
    .req        (req),
    .en         (sel.ram),
    .hard_reset (hard_reset),
    .rdata      (ram_rdata)
  );

  rom_bank_store rom_bank_store_i (
    .clk   (clk),
    .req   (req),
    .en    (sel.rom8 | sel.roma), // both basic windows
    .alt   (sel.rom_alt),
    .roma  (sel.roma),
    .ld    (ld),
    .rdata (rom_rdata)
  );

  cart_slot cart_slot_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .req          (req),
    .en           (sel.romc),
    .ld           (ld),
    .rdata        (cart_rdata),
    .cart_present (cart_present)
  );

  pia1_port_b pia1_port_b_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .req      (req),
    .en       (sel.pia1),
    .rdata    (pia_rdata),
    .bank_ctl (bank_ctl),
    .sndout   (sndout)
  );

endmodule

// ==== tb/tb_coco_tasks.svh ====
// bus drivers and directed tests
`ifndef TB_COCO_TASKS_SVH
`define TB_COCO_TASKS_SVH

// next drive point, 2 ns past the edge
task automatic tick();
  @(posedge clk);
  #2;
endtask

task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
  end
endtask

// byte image, every address bit counts
function automatic logic [7:0] image_byte(input logic [15:0] a, input logic [7:0] salt);
  return a[7:0] ^ {a[15:13], 5'h00} ^ {3'b000, a[12:8]} ^ salt;
endfunction

// setup then a single access cycle
task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [7:0] wdata,
                        output logic [7:0] rdata);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = wr;
  paddr   = addr;
  pwdata  = wdata;
  tick();
  penable = 1'b1;
  @(negedge clk); // mid access cycle, no wait states
  check_value("pready", {7'b0, pready}, 8'h01);
  rdata = prdata;
  tick(); // write lands on this edge
  psel    = 1'b0;
  penable = 1'b0;
endtask

task automatic apb_write(input logic [15:0] addr, input logic [7:0] data);
  logic [7:0] unused;
  apb_xfer(1'b1, addr, data, unused);
endtask

task automatic expect_read(input logic [15:0] addr, input logic [7:0] exp);
  logic [7:0] got;
  apb_xfer(1'b0, addr, 8'h00, got);
  check_value($sformatf("prdata[%h]", addr), got, exp);
endtask

// host download from 0 up to last, ends with the address held
task automatic load_image(input logic idx, input int last, input logic [7:0] salt);
  int a;
  ioctl_index    = idx;
  ioctl_download = 1'b1;
  for (a = 0; a <= last; a++)
  begin
    ioctl_addr = a[15:0];
    ioctl_data = image_byte(a[15:0], salt);
    ioctl_wr   = 1'b1;
    tick();
  end
  ioctl_wr = 1'b0;
  tick();
  ioctl_download = 1'b0; // falling edge judged on ioctl_addr = last
  tick();
  tick();
endtask

task automatic reset_values();
  check_value("pready", {7'b0, pready}, 8'h00);
  check_value("cart_present", {7'b0, cart_present}, 8'h00);
  check_value("sndout", {7'b0, sndout}, 8'h00);
  expect_read(16'hff22, 8'h00);
  expect_read(16'hff23, 8'h00);
endtask

task automatic ram_readback();
  logic [14:0] addr [16];
  logic [7:0]  data [16];
  int          k;
  for (k = 0; k < 16; k++)
  begin
    addr[k] = {k[3:0], 11'($urandom_range(2047))}; // one per 2k block, no overlap
    data[k] = 8'($urandom_range(255));
    apb_write({1'b0, addr[k]}, data[k]);
  end
  for (k = 0; k < 16; k++)
    expect_read({1'b0, addr[k]}, data[k]);
endtask

task automatic unmapped_reads();
  expect_read(16'hff00, 8'hff); // first pia slot
  expect_read(16'hff1f, 8'hff);
  expect_read(16'hff00 + 16'($urandom_range(31)), 8'hff);
  expect_read(16'hff40, 8'hff);
  expect_read(16'hff40 + 16'($urandom_range(191)), 8'hff);
  expect_read(16'hffff, 8'hff); // vectors
endtask

task automatic cold_start_clear();
  apb_write(16'h0070, 8'h12);
  apb_write(16'h0071, 8'h55);
  apb_write(16'h0072, 8'h34);
  expect_read(16'h0071, 8'h55);
  hard_reset = 1'b1;
  tick();
  hard_reset = 1'b0;
  tick();
  expect_read(16'h0070, 8'h12);
  expect_read(16'h0071, 8'h00);
  expect_read(16'h0072, 8'h34);
endtask

task automatic cart_load_cycle();
  check_value("cart_present", {7'b0, cart_present}, 8'h00);
  expect_read(16'hc000, 8'hff);
  load_image(coco_pkg::loader_idx_cart, 16'h0200, 8'ha5);
  check_value("cart_present", {7'b0, cart_present}, 8'h01);
  expect_read(16'hc000, image_byte(16'h0000, 8'ha5));
  expect_read(16'hc0ff, image_byte(16'h00ff, 8'ha5));
  expect_read(16'hc200, image_byte(16'h0200, 8'ha5));
  // short download, slot reads empty again
  load_image(coco_pkg::loader_idx_cart, 16'h0080, 8'h3c);
  check_value("cart_present", {7'b0, cart_present}, 8'h00);
  expect_read(16'hc000, 8'hff);
  expect_read(16'hc040, 8'hff);
endtask

// both windows; bank = {alt, window}
task automatic read_banks(input logic alt);
  logic [12:0] off [4];
  int          k;
  off[0] = 13'h0000;
  off[1] = 13'h0010; // also hit by the window writes
  off[2] = 13'h1fff;
  off[3] = 13'($urandom_range(8191));
  for (k = 0; k < 4; k++)
  begin
    expect_read({3'b100, off[k]}, image_byte({1'b0, alt, 1'b0, off[k]}, 8'h00));
    expect_read({3'b101, off[k]}, image_byte({1'b0, alt, 1'b1, off[k]}, 8'h00));
  end
endtask

task automatic rom_bank_select();
  load_image(coco_pkg::loader_idx_rom, rom_bytes - 1, 8'h00);
  dragon64 = 1'b0;
  apb_write(16'hff23, 8'h04);
  apb_write(16'hff22, 8'h00);
  read_banks(1'b0); // not a 64
  dragon64 = 1'b1;
  apb_write(16'hff23, 8'h00);
  read_banks(1'b0); // bit 2 is an input
  apb_write(16'hff23, 8'h04);
  read_banks(1'b1); // driven low, alternate banks
  apb_write(16'hff22, 8'h04);
  read_banks(1'b0);
  apb_write(16'hff22, 8'h00);
  apb_write(16'h8010, 8'h5a);
  apb_write(16'ha010, 8'ha5);
  read_banks(1'b1); // writes above left no mark
  dragon64 = 1'b0;
endtask

task automatic port_b_regs();
  logic [7:0] data [5];
  logic [7:0] ddr  [5];
  logic       snd  [5];
  int         k;
  data = '{8'h02, 8'hfd, 8'h02, 8'hff, 8'h00};
  ddr  = '{8'h02, 8'h02, 8'h00, 8'hff, 8'hff};
  snd  = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0}; // high only where bit 1 is driven high
  for (k = 0; k < 5; k++)
  begin
    apb_write(16'hff23, ddr[k]);
    apb_write(16'hff22, data[k]);
    expect_read(16'hff22, data[k]);
    expect_read(16'hff23, ddr[k]);
    check_value("sndout", {7'b0, sndout}, {7'b0, snd[k]});
  end
  expect_read(16'hff20, 8'hff); // offsets 0 and 1 not modelled
  expect_read(16'hff21, 8'hff);
endtask

`endif

// ==== tb/tb_coco_bus.sv ====
// colour computer bus testbench
`timescale 1ns/10ps
module tb_coco_bus;

  localparam int clk_half     = 10;     // 20 ns period
  localparam int rom_bytes    = 32768;  // four 8k banks
  localparam int cart_bytes   = 1024;   // bound on both cart downloads
  localparam int apb_ops      = 200;    // bound on apb transfers over all tests
  localparam int limit_cycles = 2 * (rom_bytes + cart_bytes + 3 * apb_ops) + 100;

  logic        clk;
  logic        reset_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;
  logic        dragon64;
  logic        hard_reset;
  logic        ioctl_download;
  logic        ioctl_wr;
  logic        ioctl_index;
  logic [15:0] ioctl_addr;
  logic [7:0]  ioctl_data;
  logic        cart_present;
  logic        sndout;

  int errors; // failed checks
  int checks; // all checks

  coco_bus_top coco_bus_top_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .dragon64       (dragon64),
    .hard_reset     (hard_reset),
    .ioctl_download (ioctl_download),
    .ioctl_wr       (ioctl_wr),
    .ioctl_index    (ioctl_index),
    .ioctl_addr     (ioctl_addr),
    .ioctl_data     (ioctl_data),
    .cart_present   (cart_present),
    .sndout         (sndout)
  );

  `include "tb_coco_tasks.svh"

  always #clk_half clk = ~clk;

  initial
  begin
    clk            = 1'b0;
    reset_n        = 1'b0;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    {dragon64, hard_reset} = '0;
    {ioctl_download, ioctl_wr, ioctl_index, ioctl_addr, ioctl_data} = '0;
    errors         = 0;
    checks         = 0;
    void'($urandom(32'h9f3e2dbc)); // one seed for the whole run
    repeat (4) @(posedge clk);
    #2 reset_n = 1'b1;
    reset_values();
    ram_readback();
    unmapped_reads();
    cold_start_clear();
    cart_load_cycle(); // before the rom load, any download end moves cart_present
    rom_bank_select();
    port_b_regs();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(limit_cycles * 2 * clk_half);
    $display("watchdog expired after %0d cycles, tests did not finish", limit_cycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+tb
hw/coco_pkg.sv
hw/apb_bus_slave.sv
hw/mem_map_decode.sv
hw/system_ram.sv
hw/rom_bank_store.sv
hw/cart_slot.sv
hw/pia1_port_b.sv
hw/coco_bus_top.sv
tb/tb_coco_bus.sv
